// ==== design/chip_pkg.sv ====
package chip_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Link and packet sizes

  localparam int link_channel_width_lp  = 8;
  localparam int pkt_flits_lp           = 4;
  localparam int pkt_width_lp           = link_channel_width_lp * pkt_flits_lp;
  localparam int pkt_cnt_width_lp       = $clog2(pkt_flits_lp);
  localparam int flit_cnt_width_lp      = $clog2(pkt_flits_lp + 1);
  localparam int link_fifo_depth_lp     = 8;
  localparam int lg_link_fifo_depth_lp  = $clog2(link_fifo_depth_lp);
  localparam int link_credit_width_lp   = $clog2(link_fifo_depth_lp + 1);
  localparam int lg_token_decimation_lp = 1;

  // Scratch memory geometry
  localparam int mem_els_lp        = 256;
  localparam int mem_addr_width_lp = $clog2(mem_els_lp);
  localparam int mem_data_width_lp = 16;

  // Tag network
  localparam int tag_client_lp        = 2;
  localparam int tag_id_width_lp      = $clog2(tag_client_lp);
  localparam int tag_payload_width_lp = 9;
  localparam int tag_frame_width_lp   = tag_id_width_lp + tag_payload_width_lp;
  localparam int tag_cnt_width_lp     = $clog2(tag_frame_width_lp);

  ////////////////////////////////////////////////////////////////////////////
  // Types

  typedef struct packed {
    logic                             v;
    logic [link_channel_width_lp-1:0] data;
  } chip_link_s;

  typedef enum logic [7:0] {
    op_write = 8'h01,
    op_read  = 8'h02,
    op_resp  = 8'h03
  } chip_op_e;

  typedef struct packed {
    logic [mem_addr_width_lp-1:0] addr;
    logic [mem_data_width_lp-1:0] data;
  } chip_wr_payload_s;

  typedef struct packed {
    logic [mem_addr_width_lp-1:0] addr;
    logic [mem_data_width_lp-1:0] mask;
  } chip_rd_payload_s;

  typedef struct packed {
    logic [mem_addr_width_lp-1:0] addr;
    logic [mem_data_width_lp-1:0] data;
  } chip_resp_payload_s;

  // Same 24 bits, meaning picked by the opcode
  typedef union packed {
    chip_wr_payload_s   wr;
    chip_rd_payload_s   rd;
    chip_resp_payload_s resp;
  } chip_payload_u;

  typedef struct packed {
    chip_op_e      op;
    chip_payload_u payload;
  } chip_pkt_s;

  typedef struct packed {
    logic                         link_reset;
    logic                         wp_en;
    logic [mem_addr_width_lp-1:0] wp_base;
  } chip_tag_lines_s;

endpackage

// ==== design/chip_tag_master.sv ====
`timescale 1ns/1ns

module chip_tag_master
  (input  logic                      clk_i
  ,input  logic                      rst_i
  ,input  logic                      tag_en_i
  ,input  logic                      tag_data_i
  ,output chip_pkg::chip_tag_lines_s tag_lines_o
  );

  import chip_pkg::*;

  logic                            busy_r;
  logic [tag_cnt_width_lp-1:0]     cnt_r;
  logic [tag_frame_width_lp-1:0]   shift_r;
  logic                            done_r;
  logic [tag_id_width_lp-1:0]      client_id;
  logic [tag_payload_width_lp-1:0] client_payload;
  logic                            last_bit;
  chip_tag_lines_s                 lines_r;

  ////////////////////////////////////////////////////////////////////////////
  // Frame capture

  assign last_bit = (cnt_r == tag_cnt_width_lp'(tag_frame_width_lp - 1));

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
      done_r <= 1'b0;
    end
    else
    begin
      done_r <= 1'b0;
      if (tag_en_i)
      begin
        if (!busy_r)
        begin
          // Wait for the start bit
          if (tag_data_i)
          begin
            busy_r <= 1'b1;
            cnt_r  <= '0;
          end
        end
        else
        begin
          cnt_r <= cnt_r + 1'b1;
          if (last_bit)
          begin
            busy_r <= 1'b0;
            done_r <= 1'b1;
          end
        end
      end
    end
  end

  // LSB first, so new bits enter at the top
  always_ff @(posedge clk_i)
  begin
    if (tag_en_i && busy_r)
      shift_r <= {tag_data_i, shift_r[tag_frame_width_lp-1:1]};
  end

  assign client_id      = shift_r[tag_id_width_lp-1:0];
  assign client_payload = shift_r[tag_frame_width_lp-1:tag_id_width_lp];

  ////////////////////////////////////////////////////////////////////////////
  // Client registers

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      lines_r.link_reset <= 1'b1;
      lines_r.wp_en      <= 1'b0;
      lines_r.wp_base    <= '0;
    end
    else if (done_r)
    begin
      case (client_id)
        1'b0: lines_r.link_reset <= client_payload[0];
        1'b1:
        begin
          lines_r.wp_en   <= client_payload[8];
          lines_r.wp_base <= client_payload[7:0];
        end
        default: ;
      endcase
    end
  end

  assign tag_lines_o = lines_r;

endmodule

// ==== design/chip_link_downstream.sv ====
`timescale 1ns/1ns

module chip_link_downstream
  (input  logic                 clk_i
  ,input  logic                 rst_i
  ,input  logic                 link_reset_i
  ,input  chip_pkg::chip_link_s link_i
  ,output logic                 link_tkn_o
  ,output logic                 pkt_v_o
  ,output chip_pkg::chip_pkt_s  pkt_o
  ,input  logic                 pkt_ready_i
  );

  import chip_pkg::*;

  logic [link_channel_width_lp-1:0] fifo_mem [link_fifo_depth_lp];
  logic [lg_link_fifo_depth_lp-1:0] wptr_r;
  logic [lg_link_fifo_depth_lp-1:0] rptr_r;
  logic [lg_link_fifo_depth_lp:0]   fifo_cnt_r;
  logic                             fifo_full;
  logic                             fifo_enq;
  logic                             fifo_deq;
  logic [link_channel_width_lp-1:0] fifo_head;

  logic [pkt_width_lp-link_channel_width_lp-1:0] asm_r;
  logic [pkt_cnt_width_lp-1:0]                   asm_cnt_r;
  logic                                          last_flit;
  logic                                          out_free;
  logic                                          pkt_load;

  chip_pkt_s                         pkt_r;
  logic                              pkt_v_r;
  logic [lg_token_decimation_lp-1:0] deq_cnt_r;
  logic                              tkn_r;

  ////////////////////////////////////////////////////////////////////////////
  // Receive flit FIFO

  assign fifo_full = (fifo_cnt_r == (lg_link_fifo_depth_lp+1)'(link_fifo_depth_lp));
  assign fifo_enq  = link_i.v & ~link_reset_i & ~fifo_full;
  assign fifo_head = fifo_mem[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (fifo_enq)
      fifo_mem[wptr_r] <= link_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i | link_reset_i)
    begin
      wptr_r     <= '0;
      rptr_r     <= '0;
      fifo_cnt_r <= '0;
    end
    else
    begin
      if (fifo_enq)
        wptr_r <= wptr_r + 1'b1;
      if (fifo_deq)
        rptr_r <= rptr_r + 1'b1;
      case ({fifo_enq, fifo_deq})
        2'b10:   fifo_cnt_r <= fifo_cnt_r + 1'b1;
        2'b01:   fifo_cnt_r <= fifo_cnt_r - 1'b1;
        default: fifo_cnt_r <= fifo_cnt_r;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Packet assembly

  // Last flit goes straight to the output slot
  assign last_flit = (asm_cnt_r == pkt_cnt_width_lp'(pkt_flits_lp - 1));
  assign out_free  = ~pkt_v_r | pkt_ready_i;
  assign fifo_deq  = (fifo_cnt_r != '0) & (~last_flit | out_free);
  assign pkt_load  = fifo_deq & last_flit;

  always_ff @(posedge clk_i)
  begin
    if (rst_i | link_reset_i)
      asm_cnt_r <= '0;
    else if (pkt_load)
      asm_cnt_r <= '0;
    else if (fifo_deq)
      asm_cnt_r <= asm_cnt_r + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (fifo_deq)
      asm_r <= {asm_r[pkt_width_lp-2*link_channel_width_lp-1:0], fifo_head};
    if (pkt_load)
      pkt_r <= chip_pkt_s'({asm_r, fifo_head});
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pkt_v_r <= 1'b0;
    else if (pkt_load)
      pkt_v_r <= 1'b1;
    else if (pkt_ready_i)
      pkt_v_r <= 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Token return, one per two dequeued flits

  always_ff @(posedge clk_i)
  begin
    if (rst_i | link_reset_i)
    begin
      deq_cnt_r <= '0;
      tkn_r     <= 1'b0;
    end
    else
    begin
      tkn_r <= fifo_deq & (&deq_cnt_r);
      if (fifo_deq)
        deq_cnt_r <= deq_cnt_r + 1'b1;
    end
  end

  assign link_tkn_o = tkn_r;
  assign pkt_v_o    = pkt_v_r;
  assign pkt_o      = pkt_r;

endmodule

// ==== design/chip_link_upstream.sv ====
`timescale 1ns/1ns

module chip_link_upstream
  (input  logic                 clk_i
  ,input  logic                 rst_i
  ,input  logic                 link_reset_i
  ,input  logic                 pkt_v_i
  ,input  chip_pkg::chip_pkt_s  pkt_i
  ,output logic                 pkt_ready_o
  ,output chip_pkg::chip_link_s link_o
  ,input  logic                 link_tkn_i
  );

  import chip_pkg::*;

  logic [pkt_width_lp-1:0]         buf_r;
  logic [flit_cnt_width_lp-1:0]    left_r;
  logic [link_credit_width_lp-1:0] credit_r;
  logic [link_credit_width_lp-1:0] credit_gain;
  logic [link_credit_width_lp-1:0] credit_spend;
  logic                            pkt_accept;
  logic                            flit_send;

  ////////////////////////////////////////////////////////////////////////////
  // Packet buffer and serializer

  assign pkt_ready_o = (left_r == '0);
  assign pkt_accept  = pkt_v_i & pkt_ready_o;
  assign flit_send   = (left_r != '0) & (credit_r != '0);

  always_ff @(posedge clk_i)
  begin
    if (rst_i | link_reset_i)
      left_r <= '0;
    else if (pkt_accept)
      left_r <= flit_cnt_width_lp'(pkt_flits_lp);
    else if (flit_send)
      left_r <= left_r - 1'b1;
  end

  // Most significant flit leaves first
  always_ff @(posedge clk_i)
  begin
    if (pkt_accept)
      buf_r <= pkt_i;
    else if (flit_send)
      buf_r <= {buf_r[pkt_width_lp-link_channel_width_lp-1:0],
                {link_channel_width_lp{1'b0}}};
  end

  assign link_o.v    = flit_send;
  assign link_o.data = buf_r[pkt_width_lp-1 -: link_channel_width_lp];

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter

  // Each token is worth 2^lg credits
  assign credit_gain  = link_tkn_i
                      ? link_credit_width_lp'(1 << lg_token_decimation_lp)
                      : '0;
  assign credit_spend = link_credit_width_lp'(flit_send);

  always_ff @(posedge clk_i)
  begin
    if (rst_i | link_reset_i)
      credit_r <= link_credit_width_lp'(link_fifo_depth_lp);
    else
      credit_r <= credit_r + credit_gain - credit_spend;
  end

endmodule

// ==== design/chip_core_complex.sv ====
`timescale 1ns/1ns

module chip_core_complex
  (input  logic                      clk_i
  ,input  logic                      rst_i
  ,input  chip_pkg::chip_tag_lines_s tag_lines_i
  ,input  logic                      req_v_i
  ,input  chip_pkg::chip_pkt_s       req_i
  ,output logic                      req_ready_o
  ,output logic                      resp_v_o
  ,output chip_pkg::chip_pkt_s       resp_o
  ,input  logic                      resp_ready_i
  );

  import chip_pkg::*;

  logic [mem_data_width_lp-1:0] mem_r [mem_els_lp];

  logic                         req_accept;
  logic                         is_write;
  logic                         is_read;
  logic                         wp_hit;
  logic                         do_write;
  logic                         do_read;
  logic [mem_addr_width_lp-1:0] wr_addr;
  logic [mem_data_width_lp-1:0] wr_data;
  logic [mem_addr_width_lp-1:0] rd_addr;
  logic [mem_data_width_lp-1:0] rd_mask;
  logic [mem_data_width_lp-1:0] rd_data;

  chip_pkt_s resp_r;
  logic      resp_v_r;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode

  assign req_ready_o = ~resp_v_r;
  assign req_accept  = req_v_i & req_ready_o;

  assign is_write = (req_i.op == op_write);
  assign is_read  = (req_i.op == op_read);

  assign wr_addr = req_i.payload.wr.addr;
  assign wr_data = req_i.payload.wr.data;
  assign rd_addr = req_i.payload.rd.addr;
  assign rd_mask = req_i.payload.rd.mask;

  // Protected region runs from wp_base to the top of memory
  assign wp_hit   = tag_lines_i.wp_en & (wr_addr >= tag_lines_i.wp_base);
  assign do_write = req_accept & is_write & ~wp_hit;
  assign do_read  = req_accept & is_read;

  ////////////////////////////////////////////////////////////////////////////
  // Scratch memory

  always_ff @(posedge clk_i)
  begin
    if (do_write)
      mem_r[wr_addr] <= wr_data;
  end

  assign rd_data = mem_r[rd_addr];

  ////////////////////////////////////////////////////////////////////////////
  // Response slot

  always_ff @(posedge clk_i)
  begin
    if (do_read)
    begin
      resp_r.op                <= op_resp;
      resp_r.payload.resp.addr <= rd_addr;
      resp_r.payload.resp.data <= rd_data & rd_mask;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_r <= 1'b0;
    else if (do_read)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  assign resp_v_o = resp_v_r;
  assign resp_o   = resp_r;

endmodule

// ==== design/chip_top.sv ====
`timescale 1ns/1ns

module chip_top
  (input  logic                 clk_i
  ,input  logic                 rst_i
  ,input  logic                 tag_en_i
  ,input  logic                 tag_data_i
  ,input  chip_pkg::chip_link_s link_i
  ,output logic                 link_tkn_o
  ,output chip_pkg::chip_link_s link_o
  ,input  logic                 link_tkn_i
  );

  import chip_pkg::*;

  chip_tag_lines_s tag_lines_lo;

  logic      req_v_lo;
  logic      req_ready_li;
  chip_pkt_s req_lo;

  logic      resp_v_lo;
  logic      resp_ready_li;
  chip_pkt_s resp_lo;

  ////////////////////////////////////////////////////////////////////////////
  // Tag master

  chip_tag_master u_tag_master
    (.clk_i      ( clk_i        )
    ,.rst_i      ( rst_i        )
    ,.tag_en_i   ( tag_en_i     )
    ,.tag_data_i ( tag_data_i   )
    ,.tag_lines_o( tag_lines_lo )
    );

  ////////////////////////////////////////////////////////////////////////////
  // Link and core

  chip_link_downstream u_link_down
    (.clk_i       ( clk_i                   )
    ,.rst_i       ( rst_i                   )
    ,.link_reset_i( tag_lines_lo.link_reset )
    ,.link_i      ( link_i                  )
    ,.link_tkn_o  ( link_tkn_o              )
    ,.pkt_v_o     ( req_v_lo                )
    ,.pkt_o       ( req_lo                  )
    ,.pkt_ready_i ( req_ready_li            )
    );

  chip_core_complex u_core
    (.clk_i       ( clk_i         )
    ,.rst_i       ( rst_i         )
    ,.tag_lines_i ( tag_lines_lo  )
    ,.req_v_i     ( req_v_lo      )
    ,.req_i       ( req_lo        )
    ,.req_ready_o ( req_ready_li  )
    ,.resp_v_o    ( resp_v_lo     )
    ,.resp_o      ( resp_lo       )
    ,.resp_ready_i( resp_ready_li )
    );

  chip_link_upstream u_link_up
    (.clk_i       ( clk_i                   )
    ,.rst_i       ( rst_i                   )
    ,.link_reset_i( tag_lines_lo.link_reset )
    ,.pkt_v_i     ( resp_v_lo               )
    ,.pkt_i       ( resp_lo                 )
    ,.pkt_ready_o ( resp_ready_li           )
    ,.link_o      ( link_o                  )
    ,.link_tkn_i  ( link_tkn_i              )
    );

endmodule

// ==== dv/tb_chip.sv ====
`timescale 1ns/1ns

module tb_chip;

  import chip_pkg::*;

  localparam int timeout_lp = 2000;
  localparam int credits_lp = 8;

  logic       clk_i      = 1'b0;
  logic       rst_i      = 1'b1;
  logic       tag_en_i   = 1'b0;
  logic       tag_data_i = 1'b0;
  chip_link_s link_i     = '0;
  logic       link_tkn_i = 1'b0;
  logic       link_tkn_o;
  chip_link_s link_o;

  logic [35:0] pat_mem [0:255];
  logic [7:0]  rx_mem [0:255];

  // Receive side, owned by the monitor and the token process
  int          rx_wr       = 0;
  int          tokens_rcvd = 0;
  int          tkn_sent    = 0;
  logic [1:0]  tkn_wait    = 2'd0;
  logic [31:0] rng_state   = 32'd70177;

  // Flags set by the main sequence
  logic released    = 1'b0;
  logic hold_tokens = 1'b0;

  int rx_rd       = 0;
  int flits_sent  = 0;
  int sent_base   = 0;
  int tokens_base = 0;

  chip_top u_chip_top
    (.clk_i      ( clk_i      )
    ,.rst_i      ( rst_i      )
    ,.tag_en_i   ( tag_en_i   )
    ,.tag_data_i ( tag_data_i )
    ,.link_i     ( link_i     )
    ,.link_tkn_o ( link_tkn_o )
    ,.link_o     ( link_o     )
    ,.link_tkn_i ( link_tkn_i )
    );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Partner's view of free slots in the DUT receive FIFO
  function automatic int credit_left();
    return credits_lp + (tokens_rcvd - tokens_base) * 2 - (flits_sent - sent_base);
  endfunction

  // Start bit, client id, then payload LSB first
  task automatic send_tag(input logic client, input logic [8:0] payload);
    logic [10:0] bits;
    int          i;
    bits = {payload, client, 1'b1};
    for (i = 0; i < 11; i++)
    begin
      @(posedge clk_i);
      tag_en_i   <= 1'b1;
      tag_data_i <= bits[0];
      bits       = bits >> 1;
    end
    @(posedge clk_i);
    tag_en_i   <= 1'b0;
    tag_data_i <= 1'b0;
    repeat (4) @(posedge clk_i);
  endtask

  task automatic send_pkt(input logic [31:0] pkt);
    int i;
    int timer;
    for (i = 0; i < 4; i++)
    begin
      timer = 0;
      @(posedge clk_i);
      while (credit_left() <= 0)
      begin
        link_i <= '0;
        timer++;
        if (timer > timeout_lp)
          fail_timeout("a link credit");
        @(posedge clk_i);
      end
      link_i <= {1'b1, pkt[31:24]};
      pkt = pkt << 8;
      flits_sent++;
    end
    @(posedge clk_i);
    link_i <= '0;
  endtask

  task automatic expect_pkt(input logic [31:0] exp);
    logic [31:0] got;
    int          timer;
    int          i;
    got   = '0;
    timer = 0;
    while (rx_wr - rx_rd < 4)
    begin
      @(posedge clk_i);
      timer++;
      if (timer > timeout_lp)
        fail_timeout("a response packet");
    end
    // Most significant flit arrives first
    for (i = 0; i < 4; i++)
    begin
      got = {got[23:0], rx_mem[rx_rd[7:0]]};
      rx_rd++;
    end
    check_equal(got, exp, "response packet");
  endtask

  task automatic run_idle(input logic [31:0] value);
    case (value[31:28])
      4'h1: hold_tokens <= 1'b1;
      4'h2: hold_tokens <= 1'b0;
      default: ;
    endcase
    repeat (value[15:0]) @(posedge clk_i);
    if (value[31:28] == 4'h3)
      check_equal(32'((tokens_rcvd - tokens_base) * 2), 32'(flits_sent - sent_base),
                  "tokens returned by the DUT");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Remote receiver

  always @(posedge clk_i)
  begin
    if (!rst_i)
    begin
      if (!released)
      begin
        check_equal(32'(link_o.v), 32'd0, "link_o.v before link release");
        check_equal(32'(link_tkn_o), 32'd0, "link_tkn_o before link release");
      end
      if (link_tkn_o)
        tokens_rcvd <= tokens_rcvd + 1;
      if (link_o.v)
      begin
        rx_mem[rx_wr[7:0]] <= link_o.data;
        rx_wr              <= rx_wr + 1;
        check_equal(32'((rx_wr + 1 - 2 * tkn_sent) > credits_lp), 32'd0,
                    "flits outstanding on link_o");
      end
    end
  end

  // One token per two flits taken, after a random delay
  always @(posedge clk_i)
  begin
    link_tkn_i <= 1'b0;
    if (!rst_i && !hold_tokens && (rx_wr / 2 > tkn_sent))
    begin
      if (tkn_wait == 2'd0)
      begin
        link_tkn_i <= 1'b1;
        tkn_sent   <= tkn_sent + 1;
        rng_state  <= xorshift32(rng_state);
        tkn_wait   <= rng_state[1:0];
      end
      else
        tkn_wait <= tkn_wait - 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pattern sequence

  initial
  begin
    logic [7:0]  rec;
    logic [31:0] value;
    $readmemh("dv/chip_patterns.hex", pat_mem);
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    rec = 8'd0;
    while (pat_mem[rec][35:32] != 4'h0 && rec != 8'hff)
    begin
      value = pat_mem[rec][31:0];
      case (pat_mem[rec][35:32])
        4'h1:
        begin
          send_tag(value[16], value[8:0]);
          // Partner link restarts with the DUT link
          if (!value[16] && !value[0])
          begin
            released    <= 1'b1;
            tokens_base = tokens_rcvd;
            sent_base   = flits_sent;
          end
        end
        4'h2: send_pkt(value);
        4'h3: expect_pkt(value);
        4'h4: run_idle(value);
        default:
        begin
          $display("Pattern record %0d has an unknown kind", rec);
          $display("CHECKS FAILED");
          $fatal(1);
        end
      endcase
      rec = rec + 8'd1;
    end
    check_equal(32'(rx_wr - rx_rd), 32'd0, "unclaimed response flits");
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== dv/chip_patterns.hex ====
// Record = kind (1 hex digit) then a 32-bit value (8 hex digits)
// Kinds 1 tag {client 16, payload 8:0}, 2 send, 3 expect, 4 idle {mode 31:28, cycles 15:0}, 0 end
// Idle modes 0 wait, 1 hold tokens, 2 resume tokens, 3 wait then check token count
20200ffff
400000020
100000000
201101234
2011155aa
201901111
20210ff00
303101200
20211ffff
3031155aa
20290ffff
303901111
430000040
// Protect from 0x80 up
100010180
20190dead
20110beef
20290ffff
303901111
20210ffff
30310beef
430000040
// Reads pile up while tokens are withheld
410000010
20210ffff
202110f0f
20290ff00
2021000ff
400000040
420000000
30310beef
30311050a
303901100
3031000ef
// Undefined opcodes
27f10ffff
200100000
20210ffff
30310beef
430000040
000000000

// ==== filelist.f ====
design/chip_pkg.sv
design/chip_tag_master.sv
design/chip_link_downstream.sv
design/chip_link_upstream.sv
design/chip_core_complex.sv
design/chip_top.sv
dv/tb_chip.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_chip -f filelist.f -o tb_chip \
  && ./obj_dir/tb_chip | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
  && echo "Simulation passed" \
  && exit 0 \
  || { echo "Simulation failed"; exit 1; }
